//--- hw/marin_bus_params.svh
// Marin bus configuration
// Address map, RAM depth, bus watchdog limit and interrupt line count

`ifndef MARIN_BUS_PARAMS_SVH
`define MARIN_BUS_PARAMS_SVH

// RAM window, 1 KB at 0x3000_0000
`define MARIN_RAM_BASE   32'h3000_0000
`define MARIN_RAM_MASK   32'hFFFF_FC00

// PIC window, two 16-bit registers at 0xF000_0008
`define MARIN_PIC_BASE   32'hF000_0008
`define MARIN_PIC_MASK   32'hFFFF_FFFC

`define MARIN_RAM_WORDS  512
`define MARIN_WDT_CYCLES 16
`define MARIN_IRQ_LINES  5

`endif

//--- hw/marin_bus_pkg.sv
// Marin bus types
// Wishbone field widths and the decoded slave target

`default_nettype none

package marin_bus_pkg;

  typedef logic [31:0] wb_adr_t;
  typedef logic [15:0] wb_dat_t;
  typedef logic [1:0]  wb_sel_t;

  // Target of the current bus cycle
  typedef enum logic [1:0] {
    SLV_RAM,
    SLV_PIC,
    SLV_NONE
  } slv_e;

endpackage

`default_nettype wire

//--- hw/wb_if.sv
// Wishbone bus bundle for the 16-bit system bus
// Master drives the request, slave returns read data and ack

`timescale 1ns/1ps
`default_nettype none

interface wb_if;
  import marin_bus_pkg::*;

  wb_adr_t adr;
  wb_dat_t dat_w;
  wb_dat_t dat_r;
  wb_sel_t sel;
  logic    we;
  logic    cyc;
  logic    stb;
  logic    ack;

  modport master (
    output adr, dat_w, sel, we, cyc, stb,
    input  dat_r, ack
  );

  modport slave (
    input  adr, dat_w, sel, we, cyc, stb,
    output dat_r, ack
  );

endinterface

`default_nettype wire

//--- hw/wb_arbiter.sv
// Two-master Wishbone arbiter
// Round-robin grant held for as long as the owner keeps cyc high

`timescale 1ns/1ps
`default_nettype none

module wb_arbiter (
  input  logic clk_i,
  input  logic rst_n_i,
  wb_if.slave  m0_i,
  wb_if.slave  m1_i,
  wb_if.master bus_o
);

  logic [1:0] gnt_q;
  logic       last_q;
  logic       owner_cyc;

  assign owner_cyc = (gnt_q[0] && m0_i.cyc) || (gnt_q[1] && m1_i.cyc);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gnt_q  <= 2'b00;
      last_q <= 1'b1;
    end else if (!owner_cyc) begin
      // Bus free, the master that did not own it last wins a tie
      if (m0_i.cyc && m1_i.cyc) begin
        gnt_q  <= last_q ? 2'b01 : 2'b10;
        last_q <= !last_q;
      end else if (m0_i.cyc) begin
        gnt_q  <= 2'b01;
        last_q <= 1'b0;
      end else if (m1_i.cyc) begin
        gnt_q  <= 2'b10;
        last_q <= 1'b1;
      end else begin
        gnt_q  <= 2'b00;
      end
    end
  end

  // Owner request onto the shared bus
  assign bus_o.adr   = gnt_q[1] ? m1_i.adr   : m0_i.adr;
  assign bus_o.dat_w = gnt_q[1] ? m1_i.dat_w : m0_i.dat_w;
  assign bus_o.sel   = gnt_q[1] ? m1_i.sel   : m0_i.sel;
  assign bus_o.we    = gnt_q[1] ? m1_i.we    : m0_i.we;
  assign bus_o.cyc   = owner_cyc;
  assign bus_o.stb   = (gnt_q[0] && m0_i.stb) || (gnt_q[1] && m1_i.stb);

  // Only the owner sees the response
  assign m0_i.ack   = gnt_q[0] && bus_o.ack;
  assign m1_i.ack   = gnt_q[1] && bus_o.ack;
  assign m0_i.dat_r = gnt_q[0] ? bus_o.dat_r : '0;
  assign m1_i.dat_r = gnt_q[1] ? bus_o.dat_r : '0;

endmodule

`default_nettype wire

//--- hw/wb_intercon.sv
// Wishbone interconnect
// Decodes the address to RAM or PIC and returns the selected response.
// Unmapped cycles end with 0xFFFF once the watchdog aborts them

`timescale 1ns/1ps
`default_nettype none

`include "marin_bus_params.svh"

module wb_intercon (
  input  logic clk_i,
  input  logic rst_n_i,
  wb_if.slave  bus_i,
  wb_if.master ram_o,
  wb_if.master pic_o,
  input  logic abort_i
);
  import marin_bus_pkg::*;

  slv_e slv;
  logic none_ack_q;

  always_comb begin
    if ((bus_i.adr & `MARIN_RAM_MASK) == `MARIN_RAM_BASE) begin
      slv = SLV_RAM;
    end else if ((bus_i.adr & `MARIN_PIC_MASK) == `MARIN_PIC_BASE) begin
      slv = SLV_PIC;
    end else begin
      slv = SLV_NONE;
    end
  end

  // Request fans out, strobe only to the target
  assign ram_o.adr   = bus_i.adr;
  assign ram_o.dat_w = bus_i.dat_w;
  assign ram_o.sel   = bus_i.sel;
  assign ram_o.we    = bus_i.we;
  assign ram_o.cyc   = bus_i.cyc && (slv == SLV_RAM);
  assign ram_o.stb   = bus_i.stb && (slv == SLV_RAM);

  assign pic_o.adr   = bus_i.adr;
  assign pic_o.dat_w = bus_i.dat_w;
  assign pic_o.sel   = bus_i.sel;
  assign pic_o.we    = bus_i.we;
  assign pic_o.cyc   = bus_i.cyc && (slv == SLV_PIC);
  assign pic_o.stb   = bus_i.stb && (slv == SLV_PIC);

  // Abort becomes a registered ack, like a real slave would give
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      none_ack_q <= 1'b0;
    end else begin
      none_ack_q <= abort_i && bus_i.stb && (slv == SLV_NONE);
    end
  end

  always_comb begin
    case (slv)
      SLV_RAM: begin
        bus_i.dat_r = ram_o.dat_r;
        bus_i.ack   = ram_o.ack;
      end
      SLV_PIC: begin
        bus_i.dat_r = pic_o.dat_r;
        bus_i.ack   = pic_o.ack;
      end
      default: begin
        bus_i.dat_r = '1;
        bus_i.ack   = none_ack_q;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- hw/ram16bit_wb.sv
// 16-bit Wishbone RAM
// Byte lane writes, registered read data and ack one cycle after strobe

`timescale 1ns/1ps
`default_nettype none

`include "marin_bus_params.svh"

module ram16bit_wb #(
  parameter int DEPTH = `MARIN_RAM_WORDS
) (
  input  logic clk_i,
  wb_if.slave  bus_i
);
  import marin_bus_pkg::*;

  localparam int AW = $clog2(DEPTH);

  wb_dat_t       mem [DEPTH];
  wb_dat_t       rdat_q;
  logic [AW-1:0] idx;
  logic          req;
  logic          ack_q;

  // Word index, bit 0 is the byte within the word
  assign idx = bus_i.adr[AW:1];
  assign req = bus_i.cyc && bus_i.stb && !ack_q;

  always_ff @(posedge clk_i) begin
    if (req && bus_i.we) begin
      if (bus_i.sel[0]) mem[idx][7:0]  <= bus_i.dat_w[7:0];
      if (bus_i.sel[1]) mem[idx][15:8] <= bus_i.dat_w[15:8];
    end
  end

  // One ack per strobe
  always_ff @(posedge clk_i) begin
    ack_q <= req;
    if (req) rdat_q <= mem[idx];
  end

  assign bus_i.dat_r = rdat_q;
  assign bus_i.ack   = ack_q;

endmodule

`default_nettype wire

//--- hw/mpic_wb.sv
// Programmable interrupt controller
// Latches rising edges into pending bits, masked by an enable register

`timescale 1ns/1ps
`default_nettype none

`include "marin_bus_params.svh"

module mpic_wb (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  wb_if.slave                         bus_i,
  input  logic [`MARIN_IRQ_LINES-1:0] irq_i,
  output logic                        irq_o
);
  import marin_bus_pkg::*;

  localparam int N = `MARIN_IRQ_LINES;

  logic [N-1:0] irq_q;
  logic [N-1:0] irq_d;
  logic [N-1:0] rise;
  logic [N-1:0] pend_q;
  logic [N-1:0] en_q;
  logic         req;
  logic         wr;
  logic         ack_q;
  wb_dat_t      rdat_q;

  assign rise = irq_q & ~irq_d;
  assign req  = bus_i.cyc && bus_i.stb && !ack_q;
  // Lines live in the low byte
  assign wr   = req && bus_i.we && bus_i.sel[0];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      irq_q  <= '0;
      irq_d  <= '0;
      pend_q <= '0;
      en_q   <= '0;
      ack_q  <= 1'b0;
      irq_o  <= 1'b0;
    end else begin
      irq_q <= irq_i;
      irq_d <= irq_q;
      ack_q <= req;
      // Write 1 to clear, a new edge in the same cycle still wins
      if (wr && !bus_i.adr[1]) begin
        pend_q <= (pend_q & ~bus_i.dat_w[N-1:0]) | rise;
      end else begin
        pend_q <= pend_q | rise;
      end
      if (wr && bus_i.adr[1]) en_q <= bus_i.dat_w[N-1:0];
      irq_o <= |(pend_q & en_q);
    end
  end

  // Bit 1 picks enable over pending
  always_ff @(posedge clk_i) begin
    if (req) begin
      rdat_q <= bus_i.adr[1] ? {{(16-N){1'b0}}, en_q} : {{(16-N){1'b0}}, pend_q};
    end
  end

  assign bus_i.dat_r = rdat_q;
  assign bus_i.ack   = ack_q;

endmodule

`default_nettype wire

//--- hw/wb_watchdog.sv
// Wishbone bus watchdog
// Aborts a strobe left without ack and keeps the faulting address

`timescale 1ns/1ps
`default_nettype none

`include "marin_bus_params.svh"

module wb_watchdog (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  marin_bus_pkg::wb_adr_t  adr_i,
  input  logic                    stb_i,
  input  logic                    ack_i,
  output logic                    abort_o,
  output logic                    fault_o,
  output marin_bus_pkg::wb_adr_t  fault_adr_o
);

  localparam int CNT_W = $clog2(`MARIN_WDT_CYCLES + 1);
  localparam logic [CNT_W-1:0] LIMIT = CNT_W'(`MARIN_WDT_CYCLES);

  logic [CNT_W-1:0] cnt_q;

  assign abort_o = stb_i && !ack_i && (cnt_q == LIMIT);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q       <= '0;
      fault_o     <= 1'b0;
      fault_adr_o <= '0;
    end else begin
      if (!stb_i || ack_i) begin
        cnt_q <= '0;
      end else if (cnt_q != LIMIT) begin
        cnt_q <= cnt_q + 1'b1;
      end
      // Sticky until reset
      if (abort_o) begin
        fault_o     <= 1'b1;
        fault_adr_o <= adr_i;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/marin_bus.sv
// Marin bus core
// Two Wishbone masters share RAM and PIC through arbiter and interconnect

`timescale 1ns/1ps
`default_nettype none

`include "marin_bus_params.svh"

module marin_bus (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  // Processor port
  input  marin_bus_pkg::wb_adr_t      m0_adr_i,
  input  marin_bus_pkg::wb_dat_t      m0_dat_i,
  output marin_bus_pkg::wb_dat_t      m0_dat_o,
  input  marin_bus_pkg::wb_sel_t      m0_sel_i,
  input  logic                        m0_we_i,
  input  logic                        m0_cyc_i,
  input  logic                        m0_stb_i,
  output logic                        m0_ack_o,
  // Debug port
  input  marin_bus_pkg::wb_adr_t      m1_adr_i,
  input  marin_bus_pkg::wb_dat_t      m1_dat_i,
  output marin_bus_pkg::wb_dat_t      m1_dat_o,
  input  marin_bus_pkg::wb_sel_t      m1_sel_i,
  input  logic                        m1_we_i,
  input  logic                        m1_cyc_i,
  input  logic                        m1_stb_i,
  output logic                        m1_ack_o,
  input  logic [`MARIN_IRQ_LINES-1:0] irq_i,
  output logic                        irq_o,
  output logic                        fault_o,
  output marin_bus_pkg::wb_adr_t      fault_adr_o
);

  wb_if bus_m0 ();
  wb_if bus_m1 ();
  wb_if bus_shared ();
  wb_if bus_ram ();
  wb_if bus_pic ();

  logic abort;

  assign bus_m0.adr   = m0_adr_i;
  assign bus_m0.dat_w = m0_dat_i;
  assign bus_m0.sel   = m0_sel_i;
  assign bus_m0.we    = m0_we_i;
  assign bus_m0.cyc   = m0_cyc_i;
  assign bus_m0.stb   = m0_stb_i;
  assign m0_dat_o     = bus_m0.dat_r;
  assign m0_ack_o     = bus_m0.ack;

  assign bus_m1.adr   = m1_adr_i;
  assign bus_m1.dat_w = m1_dat_i;
  assign bus_m1.sel   = m1_sel_i;
  assign bus_m1.we    = m1_we_i;
  assign bus_m1.cyc   = m1_cyc_i;
  assign bus_m1.stb   = m1_stb_i;
  assign m1_dat_o     = bus_m1.dat_r;
  assign m1_ack_o     = bus_m1.ack;

  wb_arbiter i_arbiter (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .m0_i    (bus_m0),
    .m1_i    (bus_m1),
    .bus_o   (bus_shared)
  );

  wb_intercon i_intercon (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .bus_i   (bus_shared),
    .ram_o   (bus_ram),
    .pic_o   (bus_pic),
    .abort_i (abort)
  );

  ram16bit_wb #(.DEPTH(`MARIN_RAM_WORDS)) i_ram (
    .clk_i (clk_i),
    .bus_i (bus_ram)
  );

  mpic_wb i_pic (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .bus_i   (bus_pic),
    .irq_i   (irq_i),
    .irq_o   (irq_o)
  );

  // Watches the shared bus after arbitration
  wb_watchdog i_watchdog (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .adr_i       (bus_shared.adr),
    .stb_i       (bus_shared.stb),
    .ack_i       (bus_shared.ack),
    .abort_o     (abort),
    .fault_o     (fault_o),
    .fault_adr_o (fault_adr_o)
  );

endmodule

`default_nettype wire

//--- verif/marin_bus_properties.sv
// Arbiter and handshake assertions
// Bound into every wb_arbiter instance

`timescale 1ns/1ps
`default_nettype none

module marin_bus_properties (
  input logic       clk_i,
  input logic       rst_n_i,
  input logic [1:0] gnt_i,
  input logic       m0_cyc_i,
  input logic       m0_stb_i,
  input logic       m0_ack_i,
  input logic       m1_cyc_i,
  input logic       m1_stb_i,
  input logic       m1_ack_i
);

  grant_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(gnt_i)) else $error("arbiter grant is two-hot");

  m0_ack_stb: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    m0_ack_i |-> m0_stb_i) else $error("m0 ack without m0 strobe");

  m1_ack_stb: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    m1_ack_i |-> m1_stb_i) else $error("m1 ack without m1 strobe");

  // Owner keeps the bus while its cyc stays high
  m0_grant_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (gnt_i[0] && m0_cyc_i) |=> $stable(gnt_i)) else $error("grant moved away from m0");

  m1_grant_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (gnt_i[1] && m1_cyc_i) |=> $stable(gnt_i)) else $error("grant moved away from m1");

endmodule

bind wb_arbiter marin_bus_properties i_props (
  .clk_i    (clk_i),
  .rst_n_i  (rst_n_i),
  .gnt_i    (gnt_q),
  .m0_cyc_i (m0_i.cyc),
  .m0_stb_i (m0_i.stb),
  .m0_ack_i (m0_i.ack),
  .m1_cyc_i (m1_i.cyc),
  .m1_stb_i (m1_i.stb),
  .m1_ack_i (m1_i.ack)
);

`default_nettype wire

//--- verif/marin_bus_tb.sv
// Marin bus testbench
// Replays bus operations from a data file on both master ports and checks
// read data, interrupt output and the bus fault report

`timescale 1ns/1ps
`default_nettype none

`include "marin_bus_params.svh"

module marin_bus_tb;
  import marin_bus_pkg::*;

  // Edge detect, pending and output registers
  localparam int IRQ_SETTLE = 6;

  logic                        clk;
  logic                        rst_n;
  wb_adr_t                     m0_adr;
  wb_dat_t                     m0_dat_w;
  wb_dat_t                     m0_dat_r;
  wb_sel_t                     m0_sel;
  logic                        m0_we;
  logic                        m0_cyc;
  logic                        m0_stb;
  logic                        m0_ack;
  wb_adr_t                     m1_adr;
  wb_dat_t                     m1_dat_w;
  wb_dat_t                     m1_dat_r;
  wb_sel_t                     m1_sel;
  logic                        m1_we;
  logic                        m1_cyc;
  logic                        m1_stb;
  logic                        m1_ack;
  logic [`MARIN_IRQ_LINES-1:0] irq;
  logic                        irq_out;
  logic                        fault;
  wb_adr_t                     fault_adr;

  // Operations loaded from the data file
  int      tid_q[$];
  int      mst_q[$];
  byte     kind_q[$];
  bit      pair_q[$];
  wb_adr_t adr_q[$];
  wb_dat_t dat_q[$];
  wb_sel_t sel_q[$];
  wb_dat_t exp_q[$];

  int     errors = 0;
  int     test_errs = 0;
  int     n_checks = 0;
  int     n_tests = 0;
  integer seed = 47;
  bit     loaded = 1'b0;

  marin_bus i_dut (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .m0_adr_i    (m0_adr),
    .m0_dat_i    (m0_dat_w),
    .m0_dat_o    (m0_dat_r),
    .m0_sel_i    (m0_sel),
    .m0_we_i     (m0_we),
    .m0_cyc_i    (m0_cyc),
    .m0_stb_i    (m0_stb),
    .m0_ack_o    (m0_ack),
    .m1_adr_i    (m1_adr),
    .m1_dat_i    (m1_dat_w),
    .m1_dat_o    (m1_dat_r),
    .m1_sel_i    (m1_sel),
    .m1_we_i     (m1_we),
    .m1_cyc_i    (m1_cyc),
    .m1_stb_i    (m1_stb),
    .m1_ack_o    (m1_ack),
    .irq_i       (irq),
    .irq_o       (irq_out),
    .fault_o     (fault),
    .fault_adr_o (fault_adr)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("** Error: %s is %h, expected %h", name, got, exp);
    errors++;
    test_errs++;
  endtask

  task automatic report_failure(input string what);
    $display("Failure: %s", what);
    errors++;
    test_errs++;
  endtask

  task automatic finish_test(input int tid);
    if (test_errs == 0)
      $display("test %0d passed", tid);
    else
      $display("test %0d: %0d errors", tid, test_errs);
    n_tests++;
    test_errs = 0;
  endtask

  task automatic drive_idle();
    rst_n    <= 1'b0;
    m0_adr   <= '0;
    m0_dat_w <= '0;
    m0_sel   <= '0;
    m0_we    <= 1'b0;
    m0_cyc   <= 1'b0;
    m0_stb   <= 1'b0;
    m1_adr   <= '0;
    m1_dat_w <= '0;
    m1_sel   <= '0;
    m1_we    <= 1'b0;
    m1_cyc   <= 1'b0;
    m1_stb   <= 1'b0;
    irq      <= '0;
  endtask

  // One Wishbone cycle on the processor port
  task automatic m0_access(input logic we, input wb_adr_t adr, input wb_dat_t dat,
                           input wb_sel_t sel, output wb_dat_t rdat);
    @(posedge clk);
    m0_adr   <= adr;
    m0_dat_w <= dat;
    m0_sel   <= sel;
    m0_we    <= we;
    m0_cyc   <= 1'b1;
    m0_stb   <= 1'b1;
    do @(negedge clk); while (!m0_ack);
    rdat = m0_dat_r;
    @(posedge clk);
    m0_cyc <= 1'b0;
    m0_stb <= 1'b0;
    m0_we  <= 1'b0;
  endtask

  // One Wishbone cycle on the debug port
  task automatic m1_access(input logic we, input wb_adr_t adr, input wb_dat_t dat,
                           input wb_sel_t sel, output wb_dat_t rdat);
    @(posedge clk);
    m1_adr   <= adr;
    m1_dat_w <= dat;
    m1_sel   <= sel;
    m1_we    <= we;
    m1_cyc   <= 1'b1;
    m1_stb   <= 1'b1;
    do @(negedge clk); while (!m1_ack);
    rdat = m1_dat_r;
    @(posedge clk);
    m1_cyc <= 1'b0;
    m1_stb <= 1'b0;
    m1_we  <= 1'b0;
  endtask

  task automatic run_op(input int i);
    wb_dat_t rdat;
    case (kind_q[i])
      "W", "R": begin
        if (mst_q[i] == 0)
          m0_access(kind_q[i] == "W", adr_q[i], dat_q[i], sel_q[i], rdat);
        else
          m1_access(kind_q[i] == "W", adr_q[i], dat_q[i], sel_q[i], rdat);
        if (kind_q[i] == "R") begin
          n_checks++;
          if (rdat !== exp_q[i])
            report_mismatch(mst_q[i] == 0 ? "m0_dat_o" : "m1_dat_o",
                            {16'h0, rdat}, {16'h0, exp_q[i]});
        end
      end
      "I": begin
        @(posedge clk);
        irq <= dat_q[i][`MARIN_IRQ_LINES-1:0];
        @(posedge clk);
        irq <= '0;
        repeat (IRQ_SETTLE) @(posedge clk);
        @(negedge clk);
        n_checks++;
        if (irq_out !== exp_q[i][0])
          report_mismatch("irq_o", {31'h0, irq_out}, {31'h0, exp_q[i][0]});
      end
      "F": begin
        @(negedge clk);
        n_checks++;
        if (fault !== exp_q[i][0])
          report_mismatch("fault_o", {31'h0, fault}, {31'h0, exp_q[i][0]});
        n_checks++;
        if (fault_adr !== adr_q[i])
          report_mismatch("fault_adr_o", fault_adr, adr_q[i]);
      end
      default: report_failure("unknown operation code in the test data");
    endcase
  endtask

  // A master must never see ack outside its own strobe
  always @(negedge clk) begin
    if (rst_n && m0_ack && !m0_stb)
      report_failure("m0_ack_o high while m0 is not strobing");
    if (rst_n && m1_ack && !m1_stb)
      report_failure("m1_ack_o high while m1 is not strobing");
  end

  initial begin
    wait (loaded);
    repeat (adr_q.size() * (`MARIN_WDT_CYCLES + 10) + 10) @(posedge clk);
    $display("Timeout: a bus operation was never acknowledged");
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    int          fd;
    int          rc;
    int          tid;
    int          mst;
    int          gap;
    int          cur_tid;
    int          i;
    string       line;
    string       op;
    logic [31:0] adr;
    logic [31:0] dat;
    logic [31:0] sel;
    logic [31:0] exp;

    drive_idle();
    fd = $fopen("verif/marin_bus_testdata.txt", "r");
    if (fd == 0) begin
      report_failure("cannot open verif/marin_bus_testdata.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        rc = $fgets(line, fd);
        if (line.len() > 1 && line.getc(0) != "#") begin
          rc = $sscanf(line, "%d %d %s %h %h %h %h", tid, mst, op, adr, dat, sel, exp);
          if (rc == 7) begin
            tid_q.push_back(tid);
            mst_q.push_back(mst);
            kind_q.push_back(op.getc(op.len() - 1));
            pair_q.push_back(op.len() == 2 && op.getc(0) == "P");
            adr_q.push_back(adr);
            dat_q.push_back(dat[15:0]);
            sel_q.push_back(sel[1:0]);
            exp_q.push_back(exp[15:0]);
          end
        end
      end
      $fclose(fd);
    end
    loaded = 1'b1;

    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);

    // Test 1, outputs idle after reset
    cur_tid = 1;
    n_checks++;
    if (m0_ack !== 1'b0)
      report_mismatch("m0_ack_o", {31'h0, m0_ack}, 32'h0);
    n_checks++;
    if (m1_ack !== 1'b0)
      report_mismatch("m1_ack_o", {31'h0, m1_ack}, 32'h0);
    n_checks++;
    if (irq_out !== 1'b0)
      report_mismatch("irq_o", {31'h0, irq_out}, 32'h0);
    n_checks++;
    if (fault !== 1'b0)
      report_mismatch("fault_o", {31'h0, fault}, 32'h0);

    i = 0;
    while (i < adr_q.size()) begin
      if (tid_q[i] != cur_tid) begin
        finish_test(cur_tid);
        cur_tid = tid_q[i];
      end
      gap = $unsigned($random(seed)) % 4;
      repeat (gap) @(posedge clk);
      if (pair_q[i] && i + 1 < adr_q.size()) begin
        fork
          run_op(i);
          run_op(i + 1);
        join
        i += 2;
      end else begin
        run_op(i);
        i++;
      end
    end
    finish_test(cur_tid);

    $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, errors);
    if (errors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/marin_bus_testdata.txt
# test master op address data sel expected (all but test and master in hex)
# op W write, R read, I irq pulse then check irq_o, F fault check, P prefix runs with next line
2 0 W 30000010 1234 3 0000
2 0 R 30000010 0000 3 1234
2 0 W 30000010 abcd 1 0000
2 1 R 30000010 0000 3 12cd
2 0 W 30000010 5678 2 0000
2 0 R 30000010 0000 3 56cd
3 0 PW 30000100 aaaa 3 0000
3 1 W 30000102 5555 3 0000
3 0 PR 30000100 0000 3 aaaa
3 1 R 30000102 0000 3 5555
4 0 W f000000a 0005 1 0000
4 1 R f000000a 0000 3 0005
4 0 I 00000000 0002 0 0000
4 0 I 00000000 0004 0 0001
4 1 R f0000008 0000 3 0006
4 0 W f0000008 0006 1 0000
4 0 I 00000000 0000 0 0000
5 0 R 40000000 0000 3 ffff
5 0 F 40000000 0000 0 0001
5 1 R 30000010 0000 3 56cd

//--- verilog.f
+incdir+hw
hw/marin_bus_pkg.sv
hw/wb_if.sv
hw/wb_arbiter.sv
hw/wb_intercon.sv
hw/ram16bit_wb.sv
hw/mpic_wb.sv
hw/wb_watchdog.sv
hw/marin_bus.sv
verif/marin_bus_properties.sv
verif/marin_bus_tb.sv

//--- Makefile
TOP := marin_bus_tb
LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): verilog.f hw/*.sv hw/*.svh verif/*.sv
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

lint:
	verilator --lint-only -Wall --timing --assert -f verilog.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
